//--- logic/bin_pkg.sv
package bin_pkg;

  localparam int PIX_W   = 8;
  localparam int SUM_W   = 12;  // Holds nine times 255.
  localparam int DIM_W   = 10;
  localparam int ADR_W   = 3;   // Word address.
  localparam int SUM_MAX = 9 * (2 ** PIX_W - 1);

  typedef enum logic [ADR_W-1:0] {
    REG_CTRL   = 3'd0,  // Bit 0 enable, bit 1 invert.
    REG_WIDTH  = 3'd1,
    REG_HEIGHT = 3'd2,
    REG_OFFSET = 3'd3,
    REG_STATUS = 3'd4   // Sticky frame done.
  } reg_addr_e;

  typedef enum logic [1:0] {
    FRM_IDLE,
    FRM_RUN,
    FRM_DONE
  } frame_state_e;

endpackage

//--- logic/win_if.sv
`timescale 1ns/100ps

interface win_if import bin_pkg::*; ();

  // Raster order with p4 as the centre.
  logic [PIX_W-1:0] p0;
  logic [PIX_W-1:0] p1;
  logic [PIX_W-1:0] p2;
  logic [PIX_W-1:0] p3;
  logic [PIX_W-1:0] p4;
  logic [PIX_W-1:0] p5;
  logic [PIX_W-1:0] p6;
  logic [PIX_W-1:0] p7;
  logic [PIX_W-1:0] p8;
  logic             valid;

  modport source (
    output p0, p1, p2, p3, p4, p5, p6, p7, p8, valid
  );

  modport sink (
    input p0, p1, p2, p3, p4, p5, p6, p7, p8, valid
  );

endinterface

//--- logic/bin_regs.sv
`timescale 1ns/100ps

module bin_regs import bin_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_wb_cyc,
  input  logic             i_wb_stb,
  input  logic             i_wb_we,
  input  logic [ADR_W-1:0] i_wb_adr,
  input  logic [31:0]      i_wb_dat,
  input  logic             i_frame_done,
  output logic [31:0]      o_wb_dat,
  output logic             o_wb_ack,
  output logic             o_enable,
  output logic             o_invert,
  output logic [DIM_W-1:0] o_width,
  output logic [DIM_W-1:0] o_height,
  output logic [SUM_W-1:0] o_offset
);

  logic        req;
  logic        wr;
  logic        done_flag;
  logic [31:0] rd_data;
  reg_addr_e   addr;

  assign addr = reg_addr_e'(i_wb_adr);
  assign req  = i_wb_cyc && i_wb_stb && !o_wb_ack;  // New request only.
  assign wr   = req && i_wb_we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_enable <= 1'b0;
      o_invert <= 1'b0;
      o_width  <= '0;
      o_height <= '0;
      o_offset <= '0;
    end else if (wr) begin
      case (addr)
        REG_CTRL: begin
          o_enable <= i_wb_dat[0];
          o_invert <= i_wb_dat[1];
        end
        REG_WIDTH:  o_width  <= i_wb_dat[DIM_W-1:0];
        REG_HEIGHT: o_height <= i_wb_dat[DIM_W-1:0];
        REG_OFFSET: o_offset <= i_wb_dat[SUM_W-1:0];
        default: ;
      endcase
    end
  end

  // Set beats clear when both land together.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_flag <= 1'b0;
    end else if (i_frame_done) begin
      done_flag <= 1'b1;
    end else if (wr && addr == REG_STATUS) begin
      done_flag <= 1'b0;
    end
  end

  always_comb begin
    rd_data = '0;
    case (addr)
      REG_CTRL:   rd_data[1:0]       = {o_invert, o_enable};
      REG_WIDTH:  rd_data[DIM_W-1:0] = o_width;
      REG_HEIGHT: rd_data[DIM_W-1:0] = o_height;
      REG_OFFSET: rd_data[SUM_W-1:0] = o_offset;
      REG_STATUS: rd_data[0]         = done_flag;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req) begin
      o_wb_dat <= rd_data;  // Valid with ack.
    end
  end

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    o_wb_ack |=> !o_wb_ack);

endmodule

//--- logic/line_window.sv
`timescale 1ns/100ps

module line_window import bin_pkg::*; #(
  parameter int MAX_W = 640
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_enable,
  input  logic [DIM_W-1:0] i_width,
  input  logic [DIM_W-1:0] i_height,
  input  logic [PIX_W-1:0] i_pix,
  input  logic             i_pix_valid,
  output logic             o_frame_done,
  win_if.source            win
);

  logic [PIX_W-1:0] lb_a [MAX_W];  // Previous row.
  logic [PIX_W-1:0] lb_b [MAX_W];  // Two rows back.
  logic [PIX_W-1:0] row_t [3];     // Index 2 is newest.
  logic [PIX_W-1:0] row_m [3];
  logic [PIX_W-1:0] row_b [3];
  logic [DIM_W-1:0] col;
  logic [DIM_W-1:0] row;
  logic             accept;
  logic             last_col;
  logic             frame_end;
  logic             win_valid;
  frame_state_e     state;

  assign accept    = i_enable && i_pix_valid;
  assign last_col  = (col == i_width - DIM_W'(1));
  assign frame_end = accept && last_col && (row == i_height - DIM_W'(1));

  always_ff @(posedge clk) begin
    if (accept) begin
      lb_a[col] <= i_pix;
      lb_b[col] <= lb_a[col];
      row_b     <= '{row_b[1], row_b[2], i_pix};
      row_m     <= '{row_m[1], row_m[2], lb_a[col]};
      row_t     <= '{row_t[1], row_t[2], lb_b[col]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !i_enable) begin
      col <= '0;
      row <= '0;
    end else if (accept) begin
      if (frame_end) begin
        col <= '0;
        row <= '0;
      end else if (last_col) begin
        col <= '0;
        row <= row + DIM_W'(1);
      end else begin
        col <= col + DIM_W'(1);
      end
    end
  end

  // Interior only.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid <= 1'b0;
    end else begin
      win_valid <= accept && col >= DIM_W'(2) && row >= DIM_W'(2);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !i_enable) begin
      state <= FRM_IDLE;
    end else begin
      case (state)
        FRM_RUN: begin
          if (frame_end) state <= FRM_DONE;
        end
        default: begin
          if (accept) begin
            state <= frame_end ? FRM_DONE : FRM_RUN;
          end else begin
            state <= FRM_IDLE;
          end
        end
      endcase
    end
  end

  assign o_frame_done = (state == FRM_DONE);

  assign win.p0    = row_t[0];
  assign win.p1    = row_t[1];
  assign win.p2    = row_t[2];
  assign win.p3    = row_m[0];
  assign win.p4    = row_m[1];
  assign win.p5    = row_m[2];
  assign win.p6    = row_b[0];
  assign win.p7    = row_b[1];
  assign win.p8    = row_b[2];
  assign win.valid = win_valid;

  a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
    i_enable && i_width != '0 |-> col < i_width);

endmodule

//--- logic/window_sum.sv
`timescale 1ns/100ps

module window_sum import bin_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  win_if.sink              win,
  output logic [SUM_W-1:0] o_sum,
  output logic [PIX_W-1:0] o_centre,
  output logic             o_valid
);

  logic [PIX_W-1:0] s1 [9];
  logic [PIX_W:0]   s2_pair [4];
  logic [PIX_W-1:0] s2_last;
  logic [PIX_W+1:0] s3_quad [2];
  logic [PIX_W-1:0] s3_last;
  logic [SUM_W-1:0] s4_sum;
  logic [PIX_W-1:0] centre_d [3];
  logic [3:0]       vld;

  // Payload runs every cycle while vld marks real windows.
  always_ff @(posedge clk) begin
    s1 <= '{win.p0, win.p1, win.p2, win.p3, win.p4, win.p5, win.p6, win.p7, win.p8};
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      s2_pair[i] <= {1'b0, s1[2*i]} + {1'b0, s1[2*i+1]};
    end
    s2_last <= s1[8];
  end

  always_ff @(posedge clk) begin
    s3_quad[0] <= {1'b0, s2_pair[0]} + {1'b0, s2_pair[1]};
    s3_quad[1] <= {1'b0, s2_pair[2]} + {1'b0, s2_pair[3]};
    s3_last    <= s2_last;
  end

  // Eights plus the ninth pixel.
  always_ff @(posedge clk) begin
    s4_sum <= SUM_W'(s3_quad[0]) + SUM_W'(s3_quad[1]) + SUM_W'(s3_last);
  end

  always_ff @(posedge clk) begin
    centre_d[0] <= s1[4];
    centre_d[1] <= centre_d[0];
    centre_d[2] <= centre_d[1];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld <= '0;
    end else begin
      vld <= {vld[2:0], win.valid};
    end
  end

  assign o_sum    = s4_sum;
  assign o_centre = centre_d[2];
  assign o_valid  = vld[3];

  a_sum_max: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid |-> o_sum <= SUM_W'(SUM_MAX));

endmodule

//--- logic/bin_decide.sv
`timescale 1ns/100ps

module bin_decide import bin_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [SUM_W-1:0] i_sum,
  input  logic [PIX_W-1:0] i_centre,
  input  logic             i_valid,
  input  logic [SUM_W-1:0] i_offset,
  input  logic             i_invert,
  output logic             o_bin,
  output logic             o_bin_valid
);

  localparam int CMP_W = SUM_W + 1;  // Sum plus offset carry.

  logic [CMP_W-1:0] lhs;
  logic [CMP_W-1:0] rhs;

  assign lhs = CMP_W'(i_centre) * CMP_W'(9);
  assign rhs = CMP_W'(i_sum) + CMP_W'(i_offset);

  always_ff @(posedge clk) begin
    o_bin <= (lhs > rhs) ^ i_invert;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_bin_valid <= 1'b0;
    end else begin
      o_bin_valid <= i_valid;
    end
  end

endmodule

//--- logic/bin_top.sv
`timescale 1ns/100ps

module bin_top import bin_pkg::*; #(
  parameter int MAX_W = 640
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_wb_cyc,
  input  logic             i_wb_stb,
  input  logic             i_wb_we,
  input  logic [ADR_W-1:0] i_wb_adr,
  input  logic [31:0]      i_wb_dat,
  input  logic [PIX_W-1:0] i_pix,
  input  logic             i_pix_valid,
  output logic [31:0]      o_wb_dat,
  output logic             o_wb_ack,
  output logic             o_bin,
  output logic             o_bin_valid
);

  logic             enable;
  logic             invert;
  logic [DIM_W-1:0] width;
  logic [DIM_W-1:0] height;
  logic [SUM_W-1:0] offset;
  logic             frame_done;
  logic [SUM_W-1:0] sum;
  logic [PIX_W-1:0] centre;
  logic             sum_valid;

  win_if win ();

  bin_regs i_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_wb_cyc     (i_wb_cyc),
    .i_wb_stb     (i_wb_stb),
    .i_wb_we      (i_wb_we),
    .i_wb_adr     (i_wb_adr),
    .i_wb_dat     (i_wb_dat),
    .i_frame_done (frame_done),
    .o_wb_dat     (o_wb_dat),
    .o_wb_ack     (o_wb_ack),
    .o_enable     (enable),
    .o_invert     (invert),
    .o_width      (width),
    .o_height     (height),
    .o_offset     (offset)
  );

  line_window #(
    .MAX_W (MAX_W)
  ) i_window (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_enable     (enable),
    .i_width      (width),
    .i_height     (height),
    .i_pix        (i_pix),
    .i_pix_valid  (i_pix_valid),
    .o_frame_done (frame_done),
    .win          (win.source)
  );

  window_sum i_sum (
    .clk      (clk),
    .rst_n    (rst_n),
    .win      (win.sink),
    .o_sum    (sum),
    .o_centre (centre),
    .o_valid  (sum_valid)
  );

  bin_decide i_decide (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_sum       (sum),
    .i_centre    (centre),
    .i_valid     (sum_valid),
    .i_offset    (offset),
    .i_invert    (invert),
    .o_bin       (o_bin),
    .o_bin_valid (o_bin_valid)
  );

endmodule

//--- tests/tb_bin.sv
`timescale 1ns/100ps

module tb_bin import bin_pkg::*; ();

  logic             clk;
  logic             rst_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [ADR_W-1:0] wb_adr;
  logic [31:0]      wb_dat_w;
  logic [31:0]      wb_dat_r;
  logic             wb_ack;
  logic [PIX_W-1:0] pix;
  logic             pix_valid;
  logic             bin;
  logic             bin_valid;

  logic [PIX_W-1:0] img [8][16];  // Row, column.
  bit               exp_q [$];
  int               errors;
  int               checks;
  int               out_cnt;
  int               err_start;

  bin_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_wb_cyc    (wb_cyc),
    .i_wb_stb    (wb_stb),
    .i_wb_we     (wb_we),
    .i_wb_adr    (wb_adr),
    .i_wb_dat    (wb_dat_w),
    .i_pix       (pix),
    .i_pix_valid (pix_valid),
    .o_wb_dat    (wb_dat_r),
    .o_wb_ack    (wb_ack),
    .o_bin       (bin),
    .o_bin_valid (bin_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Foreground when nine times the centre beats the 3x3 sum plus offset.
  function automatic bit ref_bit(int r, int c, int offset, bit invert);
    int sum;
    sum = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        sum += int'(img[r+dr][c+dc]);
      end
    end
    return ((9 * int'(img[r][c])) > (sum + offset)) ^ invert;
  endfunction

  task automatic wb_xfer(input bit we, input logic [ADR_W-1:0] adr, input logic [31:0] wdat,
                         output logic [31:0] rdat);
    int t;
    t = 0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(negedge clk);
      t++;
    end while (!wb_ack && t < 20);
    rdat = wb_dat_r;
    if (!wb_ack) begin
      errors++;
      $display("Wishbone timeout: no ack for address %0d", adr);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    wb_xfer(1'b1, adr, wdat, unused);
  endtask

  task automatic check_reg(input logic [ADR_W-1:0] adr, input logic [31:0] exp_val);
    logic [31:0] rdat;
    wb_xfer(1'b0, adr, '0, rdat);
    checks++;
    if (rdat !== exp_val) begin
      errors++;
      $display("Fail at %0t: o_wb_dat (reg %0d) got %h expected %h", $time, adr, rdat, exp_val);
    end
  endtask

  task automatic run_frame(input int w, input int h, input int offset, input bit invert,
                           input bit gaps, input bit fresh);
    int t;
    if (fresh) begin
      for (int r = 0; r < h; r++) begin
        for (int c = 0; c < w; c++) img[r][c] = PIX_W'($urandom);
      end
    end
    for (int r = 1; r < h - 1; r++) begin
      for (int c = 1; c < w - 1; c++) exp_q.push_back(ref_bit(r, c, offset, invert));
    end
    wb_write(REG_CTRL, 32'd0);
    wb_write(REG_WIDTH, 32'(w));
    wb_write(REG_HEIGHT, 32'(h));
    wb_write(REG_OFFSET, 32'(offset));
    wb_write(REG_CTRL, {30'd0, invert, 1'b1});
    out_cnt = 0;
    for (int r = 0; r < h; r++) begin
      for (int c = 0; c < w; c++) begin
        if (gaps) begin
          repeat ($urandom % 3) begin
            @(negedge clk);
            pix_valid = 1'b0;  // Idle cycle.
          end
        end
        @(negedge clk);
        pix       = img[r][c];
        pix_valid = 1'b1;
      end
    end
    @(negedge clk);
    pix_valid = 1'b0;
    t = 0;
    while (exp_q.size() != 0 && t < 100) begin
      @(negedge clk);
      t++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout: %0d expected outputs never arrived", exp_q.size());
      exp_q.delete();
    end
    checks++;
    if (out_cnt != (w - 2) * (h - 2)) begin
      errors++;
      $display("Fail at %0t: out_cnt got %0d expected %0d", $time, out_cnt, (w - 2) * (h - 2));
    end
  endtask

  task automatic test_done(input string name);
    $display("%s: %s", name, (errors == err_start) ? "passed" : "failed");
    err_start = errors;
  endtask

  // Compares every output against the head of the queue.
  initial begin
    bit exp_bit;
    forever begin
      @(negedge clk);
      if (bin_valid) begin
        out_cnt++;
        checks++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected output at %0t with nothing expected", $time);
        end else begin
          exp_bit = exp_q.pop_front();
          if (bin !== exp_bit) begin
            errors++;
            $display("Fail at %0t: o_bin got %b expected %b", $time, bin, exp_bit);
          end
        end
      end
    end
  end

  initial begin
    int t;
    int offset;
    void'($urandom(32'h2a58_308e));
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    pix       = '0;
    pix_valid = 1'b0;
    errors    = 0;
    checks    = 0;
    out_cnt   = 0;
    err_start = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    for (int a = 0; a < 5; a++) check_reg(ADR_W'(a), 32'd0);
    wb_write(REG_WIDTH, 32'h2a5);
    wb_write(REG_HEIGHT, 32'h35a);
    wb_write(REG_OFFSET, 32'ha5a);
    wb_write(REG_CTRL, 32'd2);  // Invert only.
    check_reg(REG_WIDTH, 32'h2a5);
    check_reg(REG_HEIGHT, 32'h35a);
    check_reg(REG_OFFSET, 32'ha5a);
    check_reg(REG_CTRL, 32'd2);
    wb_write(REG_CTRL, 32'd1);  // Enable alone with no pixels sent.
    check_reg(REG_CTRL, 32'd1);
    test_done("test 1 register access");

    run_frame(8, 6, 0, 1'b0, 1'b0, 1'b1);
    test_done("test 2 small random frame");

    offset = $urandom % 200;
    run_frame(16, 5, offset, 1'b1, 1'b0, 1'b1);
    test_done("test 3 offset and invert");

    run_frame(16, 5, offset, 1'b1, 1'b1, 1'b0);  // Same image with gaps.
    test_done("test 4 gapped input");

    check_reg(REG_STATUS, 32'd1);
    wb_write(REG_STATUS, 32'd0);
    check_reg(REG_STATUS, 32'd0);
    test_done("test 5 frame done");

    wb_write(REG_CTRL, 32'd0);
    out_cnt = 0;
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      pix       = PIX_W'($urandom);
      pix_valid = 1'b1;
    end
    @(negedge clk);
    pix_valid = 1'b0;
    t = 0;
    while (out_cnt == 0 && t < 40) begin
      @(negedge clk);
      t++;
    end
    checks++;
    if (out_cnt != 0) begin
      errors++;
      $display("Fail at %0t: o_bin_valid count got %0d expected 0", $time, out_cnt);
    end
    test_done("test 6 enable low");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
logic/bin_pkg.sv
logic/win_if.sv
logic/bin_regs.sv
logic/line_window.sv
logic/window_sum.sv
logic/bin_decide.sv
logic/bin_top.sv
tests/tb_bin.sv

//--- run.sh
#!/bin/sh
# Builds and runs the binarizer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_bin -f flist.f -o tb_bin > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/tb_bin > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
  exit 0
fi
exit 1
